// ==== filelist.f ====
source/etx_pkg.sv
source/etx_fifo.sv
source/etx_arbiter.sv
source/etx_cfg.sv
source/etx_top.sv
verification/etx_tb.sv

// ==== Makefile ====
# Verilator build and run for the eMesh transmit testbench

VERILATOR ?= verilator
TOP       ?= etx_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation FAILED, no result line in $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/etx_tb.sv ====
// Testbench for the eMesh transmit side
// IO sink acks each packet after a random delay of 0 to 3 cycles
// Expected packets come from per-channel scoreboards and an order queue
// Config changes and count reads happen only while the link is idle
// Stops at the first mismatch or timeout
module etx_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import etx_pkg::*;

  localparam logic [1:0] CH_WR = 2'd0;
  localparam logic [1:0] CH_RD = 2'd1;
  localparam logic [1:0] CH_RR = 2'd2;
  localparam int NUM_ROWS = 8;
  // Cycle budget for any single wait
  localparam int WAIT_LIMIT = 200;

  // One directed transfer and its expected ctrlmode field
  typedef struct packed {
    logic [1:0] chan;
    packet_t    pkt;
    logic       bypass;
    ctrlmode_t  mode;
    ctrlmode_t  exp_ctrl;
  } row_t;

  logic        tx_lclk_div4;
  logic        reset;
  logic        wr_push;
  logic        rd_push;
  logic        rr_push;
  packet_t     wr_packet;
  packet_t     rd_packet;
  packet_t     rr_packet;
  logic        etx_wr_wait;
  logic        etx_rd_wait;
  logic        etx_ack = 1'b0;
  wb_req_t     wb_req;
  logic        wr_full;
  logic        rd_full;
  logic        rr_full;
  logic        etx_access;
  packet_t     etx_packet;
  wb_rsp_t     wb_rsp;

  row_t        rows [NUM_ROWS];
  // One scoreboard per channel
  packet_t     exp_wr_q [$];
  packet_t     exp_rd_q [$];
  packet_t     exp_rr_q [$];
  // Channel order predicted from the priority rule
  logic [1:0]  order_q [$];
  int unsigned accept_count = 0;
  int unsigned push_count;
  int unsigned seq;
  logic        cur_bypass;
  ctrlmode_t   cur_mode;
  // IO sink state
  logic        sink_en;
  logic        sink_armed;
  int unsigned sink_delay;
  // Hold monitor state
  logic        hold_valid;
  packet_t     hold_pkt;

  initial
  begin
    tx_lclk_div4 = 1'b0;
    forever #4 tx_lclk_div4 = ~tx_lclk_div4;
  end

  etx_top uut (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .wr_push      (wr_push),
    .rd_push      (rd_push),
    .rr_push      (rr_push),
    .wr_packet    (wr_packet),
    .rd_packet    (rd_packet),
    .rr_packet    (rr_packet),
    .etx_wr_wait  (etx_wr_wait),
    .etx_rd_wait  (etx_rd_wait),
    .etx_ack      (etx_ack),
    .wb_req       (wb_req),
    .wr_full      (wr_full),
    .rd_full      (rd_full),
    .rr_full      (rr_full),
    .etx_access   (etx_access),
    .etx_packet   (etx_packet),
    .wb_rsp       (wb_rsp)
  );

  // ####################################################################
  // Helpers
  // ####################################################################

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual)
    begin
      $display("[ERROR] %0d ns %s expected %h got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // Address and data fields depend on n so packets stay distinct
  function automatic packet_t make_packet(input int unsigned n, input ctrlmode_t ctrl);
    packet_t p;
    p.srcaddr  = 32'ha000_0000 + n;
    p.data     = 32'h1234_0000 ^ (n * 32'h0101_0101);
    p.dstaddr  = 32'h8000_0100 + (n << 4);
    p.ctrlmode = ctrl;
    p.datamode = 2'(n);
    p.write    = n[0];
    p.access   = 1'b1;
    return p;
  endfunction

  // Bypass replaces ctrlmode on host writes and read requests only
  function automatic packet_t expected_packet(input logic [1:0] chan, input packet_t pkt,
                                              input logic bp, input ctrlmode_t mode);
    packet_t p;
    p = pkt;
    if (bp && (chan != CH_RR))
    begin
      p.ctrlmode = mode;
    end
    return p;
  endfunction

  task automatic load_table();
    rows[0] = '{CH_WR, make_packet(0, 4'h3), 1'b0, 4'h0, 4'h3};
    rows[1] = '{CH_RD, make_packet(1, 4'h7), 1'b0, 4'h0, 4'h7};
    rows[2] = '{CH_RR, make_packet(2, 4'h1), 1'b0, 4'h0, 4'h1};
    rows[3] = '{CH_WR, make_packet(3, 4'h3), 1'b1, 4'ha, 4'ha};
    rows[4] = '{CH_RD, make_packet(4, 4'h0), 1'b1, 4'ha, 4'ha};
    rows[5] = '{CH_RR, make_packet(5, 4'h2), 1'b1, 4'ha, 4'h2};
    rows[6] = '{CH_RD, make_packet(6, 4'hf), 1'b1, 4'h5, 4'h5};
    // Mode stays stored but bypass is off
    rows[7] = '{CH_WR, make_packet(7, 4'h9), 1'b0, 4'h5, 4'h9};
  endtask

  task automatic queue_expected(input logic [1:0] chan, input packet_t pkt);
    case (chan)
      CH_WR:   exp_wr_q.push_back(pkt);
      CH_RD:   exp_rd_q.push_back(pkt);
      default: exp_rr_q.push_back(pkt);
    endcase
    push_count++;
  endtask

  // One push cycle on the selected channels
  task automatic push_channels(input logic [2:0] sel, input packet_t pw, input packet_t pr,
                               input packet_t prr);
    @(posedge tx_lclk_div4);
    if (sel[0])
    begin
      check_value("wr_full", 1'b0, wr_full);
    end
    if (sel[1])
    begin
      check_value("rd_full", 1'b0, rd_full);
    end
    if (sel[2])
    begin
      check_value("rr_full", 1'b0, rr_full);
    end
    wr_push   <= sel[0];
    rd_push   <= sel[1];
    rr_push   <= sel[2];
    wr_packet <= pw;
    rd_packet <= pr;
    rr_packet <= prr;
    @(posedge tx_lclk_div4);
    wr_push <= 1'b0;
    rd_push <= 1'b0;
    rr_push <= 1'b0;
  endtask

  // Fresh packets on the selected channels under the current config
  task automatic push_group(input logic [2:0] sel);
    packet_t p [3];
    for (int c = 0; c < 3; c++)
    begin
      p[c] = make_packet(seq, 4'(seq));
      seq++;
      if (sel[c])
      begin
        queue_expected(2'(c), expected_packet(2'(c), p[c], cur_bypass, cur_mode));
      end
    end
    push_channels(sel, p[0], p[1], p[2]);
  endtask

  task automatic wait_accepts(input int unsigned target, input string what);
    int cycles;
    cycles = 0;
    while (accept_count < target)
    begin
      @(posedge tx_lclk_div4);
      cycles++;
      if (cycles > WAIT_LIMIT)
      begin
        $display("Timed out waiting for %s to leave on the IO side", what);
        abort_run();
      end
    end
  endtask

  // Classic cycle with stb dropped on the ack edge
  task automatic wb_transfer(input logic we, input cfg_adr_t adr, input data_t wdata,
                             output data_t rdata);
    int cycles;
    cycles = 0;
    @(posedge tx_lclk_div4);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
    do
    begin
      @(posedge tx_lclk_div4);
      cycles++;
      if (cycles > WAIT_LIMIT)
      begin
        $display("Timed out waiting for the Wishbone ack");
        abort_run();
      end
    end
    while (!wb_rsp.ack);
    rdata = wb_rsp.dat_r;
    wb_req <= '0;
  endtask

  // Write control register and read it back
  task automatic configure(input logic bp, input ctrlmode_t mode);
    data_t rd;
    wb_transfer(1'b1, CFG_CTRL_ADR, {27'd0, bp, mode}, rd);
    cur_bypass = bp;
    cur_mode   = mode;
    wb_transfer(1'b0, CFG_CTRL_ADR, '0, rd);
    check_value("cfg_ctrl", {27'd0, bp, mode}, rd);
  endtask

  // Count register against the sink and against the pushes
  task automatic check_count();
    data_t rd;
    wb_transfer(1'b0, CFG_COUNT_ADR, '0, rd);
    check_value("cfg_count", accept_count, rd);
    check_value("cfg_count", push_count, rd);
  endtask

  // Pop the predicted channel and compare
  task automatic take_packet(input packet_t pkt);
    logic [1:0] chan;
    packet_t    exp;
    if (order_q.size() == 0)
    begin
      $display("Unexpected transaction on the IO side at %0d ns", $time);
      abort_run();
    end
    else
    begin
      chan = order_q.pop_front();
      case (chan)
        CH_WR:   exp = exp_wr_q.pop_front();
        CH_RD:   exp = exp_rd_q.pop_front();
        default: exp = exp_rr_q.pop_front();
      endcase
      check_value("etx_packet", exp, pkt);
    end
  endtask

  // ####################################################################
  // IO sink and hold monitor
  // ####################################################################

  always @(posedge tx_lclk_div4)
  begin
    int unsigned delay;
    if (reset || !sink_en)
    begin
      etx_ack    <= 1'b0;
      sink_armed <= 1'b0;
    end
    else if (etx_access && etx_ack)
    begin
      take_packet(etx_packet);
      accept_count <= accept_count + 1;
      etx_ack      <= 1'b0;
      sink_armed   <= 1'b0;
    end
    else if (etx_access)
    begin
      // New packet draws its own delay
      delay = sink_armed ? sink_delay : ($urandom % 4);
      if (delay == 0)
      begin
        etx_ack <= 1'b1;
      end
      else
      begin
        sink_delay <= delay - 1;
      end
      sink_armed <= 1'b1;
    end
  end

  // Packet must sit still until acked
  always @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      hold_valid <= 1'b0;
    end
    else
    begin
      if (hold_valid)
      begin
        check_value("etx_access", 1'b1, etx_access);
        check_value("etx_packet", hold_pkt, etx_packet);
      end
      hold_valid <= etx_access && !etx_ack;
      hold_pkt   <= etx_packet;
    end
  end

  // ####################################################################
  // Main sequence
  // ####################################################################

  initial
  begin
    int unsigned base;
    packet_t     exp_pkt;
    void'($urandom(32'h576e));
    reset       = 1'b1;
    wr_push     = 1'b0;
    rd_push     = 1'b0;
    rr_push     = 1'b0;
    wr_packet   = '0;
    rd_packet   = '0;
    rr_packet   = '0;
    etx_wr_wait = 1'b0;
    etx_rd_wait = 1'b0;
    wb_req      = '0;
    sink_en     = 1'b1;
    push_count  = 0;
    seq         = 16;
    cur_bypass  = 1'b0;
    cur_mode    = '0;
    load_table();
    repeat (16) @(posedge tx_lclk_div4);
    reset <= 1'b0;

    // Pass-through and bypass with one packet at a time
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if ((rows[i].bypass !== cur_bypass) || (rows[i].mode !== cur_mode))
      begin
        configure(rows[i].bypass, rows[i].mode);
      end
      order_q.push_back(rows[i].chan);
      exp_pkt          = rows[i].pkt;
      exp_pkt.ctrlmode = rows[i].exp_ctrl;
      queue_expected(rows[i].chan, exp_pkt);
      push_channels(3'b001 << rows[i].chan, rows[i].pkt, rows[i].pkt, rows[i].pkt);
      wait_accepts(push_count, "a table packet");
    end
    check_count();

    // Priority with all FIFOs loaded together and ack held low
    configure(1'b1, 4'hc);
    @(posedge tx_lclk_div4);
    sink_en <= 1'b0;
    base = accept_count;
    repeat (2) order_q.push_back(CH_WR);
    repeat (2) order_q.push_back(CH_RD);
    repeat (2) order_q.push_back(CH_RR);
    push_group(3'b111);
    push_group(3'b111);
    repeat (6) @(posedge tx_lclk_div4);
    // First write is held on the link until the sink comes back
    check_value("etx_access", 1'b1, etx_access);
    check_value("etx_packet", exp_wr_q[0], etx_packet);
    sink_en <= 1'b1;
    wait_accepts(base + 6, "the priority burst");
    check_count();

    // Write wait holds wr and rr
    configure(1'b1, 4'h6);
    @(posedge tx_lclk_div4);
    etx_wr_wait <= 1'b1;
    base = accept_count;
    repeat (2) order_q.push_back(CH_RD);
    repeat (2) order_q.push_back(CH_WR);
    repeat (2) order_q.push_back(CH_RR);
    push_group(3'b111);
    push_group(3'b111);
    wait_accepts(base + 2, "read requests under write wait");
    repeat (8) @(posedge tx_lclk_div4);
    check_value("accept_count", base + 2, accept_count);
    etx_wr_wait <= 1'b0;
    wait_accepts(base + 6, "queued writes after write wait");

    // Read wait holds rd only
    configure(1'b0, 4'h6);
    @(posedge tx_lclk_div4);
    etx_rd_wait <= 1'b1;
    base = accept_count;
    repeat (2) order_q.push_back(CH_WR);
    repeat (2) order_q.push_back(CH_RR);
    repeat (2) order_q.push_back(CH_RD);
    push_group(3'b111);
    push_group(3'b111);
    wait_accepts(base + 4, "writes and responses under read wait");
    repeat (8) @(posedge tx_lclk_div4);
    check_value("accept_count", base + 4, accept_count);
    etx_rd_wait <= 1'b0;
    wait_accepts(base + 6, "queued read requests after read wait");

    check_count();
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== source/etx_top.sv ====
// Transmit side top: three channel FIFOs, arbiter and config slave
// All inputs on tx_lclk_div4, clock crossing lives outside
// Minimum push to etx_access latency is two cycles
// Serializer and receive side are not included
module etx_top (
  input  logic              tx_lclk_div4,
  input  logic              reset,
  input  logic              wr_push,
  input  logic              rd_push,
  input  logic              rr_push,
  input  etx_pkg::packet_t  wr_packet,
  input  etx_pkg::packet_t  rd_packet,
  input  etx_pkg::packet_t  rr_packet,
  input  logic              etx_wr_wait,
  input  logic              etx_rd_wait,
  input  logic              etx_ack,
  input  etx_pkg::wb_req_t  wb_req,
  output logic              wr_full,
  output logic              rd_full,
  output logic              rr_full,
  output logic              etx_access,
  output etx_pkg::packet_t  etx_packet,
  output etx_pkg::wb_rsp_t  wb_rsp
);
  import etx_pkg::*;

  // FIFO to arbiter
  logic      wr_empty;
  logic      rd_empty;
  logic      rr_empty;
  logic      wr_pop;
  logic      rd_pop;
  logic      rr_pop;
  packet_t   wr_head;
  packet_t   rd_head;
  packet_t   rr_head;
  // Config to arbiter
  logic      bypass;
  ctrlmode_t ctrlmode;

  // ####################################################################
  // Channel FIFOs
  // ####################################################################

  // Host writes
  etx_fifo u_wr_fifo (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .push         (wr_push),
    .push_packet  (wr_packet),
    .pop          (wr_pop),
    .full         (wr_full),
    .empty        (wr_empty),
    .head         (wr_head)
  );

  // Host read requests
  etx_fifo u_rd_fifo (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .push         (rd_push),
    .push_packet  (rd_packet),
    .pop          (rd_pop),
    .full         (rd_full),
    .empty        (rd_empty),
    .head         (rd_head)
  );

  // Read responses
  etx_fifo u_rr_fifo (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .push         (rr_push),
    .push_packet  (rr_packet),
    .pop          (rr_pop),
    .full         (rr_full),
    .empty        (rr_empty),
    .head         (rr_head)
  );

  // ####################################################################
  // Arbiter and config
  // ####################################################################

  etx_arbiter u_arbiter (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .wr_empty     (wr_empty),
    .rd_empty     (rd_empty),
    .rr_empty     (rr_empty),
    .wr_head      (wr_head),
    .rd_head      (rd_head),
    .rr_head      (rr_head),
    .bypass       (bypass),
    .ctrlmode     (ctrlmode),
    .etx_wr_wait  (etx_wr_wait),
    .etx_rd_wait  (etx_rd_wait),
    .etx_ack      (etx_ack),
    .wr_pop       (wr_pop),
    .rd_pop       (rd_pop),
    .rr_pop       (rr_pop),
    .etx_access   (etx_access),
    .etx_packet   (etx_packet)
  );

  // Counts transfers seen on the IO handshake
  etx_cfg u_cfg (
    .tx_lclk_div4 (tx_lclk_div4),
    .reset        (reset),
    .wb_req       (wb_req),
    .etx_access   (etx_access),
    .etx_ack      (etx_ack),
    .wb_rsp       (wb_rsp),
    .bypass       (bypass),
    .ctrlmode     (ctrlmode)
  );

endmodule

// ==== source/etx_cfg.sv ====
// Wishbone classic config slave for the transmit path
// Ack is registered and lasts one cycle, host must drop stb on ack
// Offset 0 holds ctrlmode and bypass, offset 4 the accepted count
// Unmapped offsets read as zero and ignore writes
module etx_cfg (
  input  logic                tx_lclk_div4,
  input  logic                reset,
  input  etx_pkg::wb_req_t    wb_req,
  input  logic                etx_access,
  input  logic                etx_ack,
  output etx_pkg::wb_rsp_t    wb_rsp,
  output logic                bypass,
  output etx_pkg::ctrlmode_t  ctrlmode
);
  import etx_pkg::*;

  // New request not yet acked
  logic  wb_hit;
  logic  ack_q;
  data_t dat_r_q;
  // Transactions accepted by the IO side
  data_t tx_count;
  data_t rd_data;

  assign wb_hit = wb_req.cyc & wb_req.stb & ~ack_q;

  // ####################################################################
  // Read decode
  // ####################################################################

  always_comb
  begin
    rd_data = '0;
    case (wb_req.adr)
      CFG_CTRL_ADR:
      begin
        rd_data[3:0]            = ctrlmode;
        rd_data[CFG_BYPASS_BIT] = bypass;
      end
      CFG_COUNT_ADR: rd_data = tx_count;
      default:       rd_data = '0;
    endcase
  end

  // ####################################################################
  // Bus handshake and registers
  // ####################################################################

  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      ack_q    <= 1'b0;
      bypass   <= 1'b0;
      ctrlmode <= '0;
    end
    else
    begin
      ack_q <= wb_hit;
      // Write lands on the same edge as ack
      if (wb_hit && wb_req.we && (wb_req.adr == CFG_CTRL_ADR))
      begin
        bypass   <= wb_req.dat_w[CFG_BYPASS_BIT];
        ctrlmode <= wb_req.dat_w[3:0];
      end
    end
  end

  // Read data captured alongside ack
  always_ff @(posedge tx_lclk_div4)
  begin
    if (wb_hit)
    begin
      dat_r_q <= rd_data;
    end
  end

  // Accepted transfer counter, wraps at 2**32
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      tx_count <= '0;
    end
    else if (etx_access && etx_ack)
    begin
      tx_count <= tx_count + 1'b1;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat_r: dat_r_q};

  // Single-cycle ack even with stb held
  a_ack_single: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("etx_cfg ack held two cycles");

endmodule

// ==== source/etx_arbiter.sv ====
// Fixed-priority transmit arbiter: host writes, then read requests,
// then read responses
// Read requests can starve read responses under heavy load
// Read responses follow the write wait since they travel as writes
// Output packet is held until the IO side acknowledges it
module etx_arbiter (
  input  logic                tx_lclk_div4,
  input  logic                reset,
  input  logic                wr_empty,
  input  logic                rd_empty,
  input  logic                rr_empty,
  input  etx_pkg::packet_t    wr_head,
  input  etx_pkg::packet_t    rd_head,
  input  etx_pkg::packet_t    rr_head,
  input  logic                bypass,
  input  etx_pkg::ctrlmode_t  ctrlmode,
  input  logic                etx_wr_wait,
  input  logic                etx_rd_wait,
  input  logic                etx_ack,
  output logic                wr_pop,
  output logic                rd_pop,
  output logic                rr_pop,
  output logic                etx_access,
  output etx_pkg::packet_t    etx_packet
);
  import etx_pkg::*;

  logic    wr_ready;
  logic    rd_ready;
  logic    rr_ready;
  // Output slot free or about to be freed
  logic    slot_free;
  logic    any_pop;
  // wr and rd heads after control mode override
  packet_t wr_sub;
  packet_t rd_sub;

  // Override the ctrlmode field when bypass is on
  function automatic packet_t apply_ctrlmode(input packet_t pkt, input logic bp,
                                             input ctrlmode_t mode);
    packet_t result;
    result = pkt;
    if (bp)
    begin
      result.ctrlmode = mode;
    end
    return result;
  endfunction

  // ####################################################################
  // Priority and pops
  // ####################################################################

  // Highest priority
  assign wr_ready = ~wr_empty & ~etx_wr_wait;
  assign rd_ready = ~rd_empty & ~etx_rd_wait & ~wr_ready;
  // Lowest, gated by the write wait
  assign rr_ready = ~rr_empty & ~etx_wr_wait & ~wr_ready & ~rd_ready;

  // Ack in the same cycle allows back-to-back transfers
  assign slot_free = ~etx_access | etx_ack;

  assign wr_pop  = wr_ready & slot_free;
  assign rd_pop  = rd_ready & slot_free;
  assign rr_pop  = rr_ready & slot_free;
  assign any_pop = wr_pop | rd_pop | rr_pop;

  // Host-side channels only
  assign wr_sub = apply_ctrlmode(wr_head, bypass, ctrlmode);
  assign rd_sub = apply_ctrlmode(rd_head, bypass, ctrlmode);

  // ####################################################################
  // Output register
  // ####################################################################

  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      etx_access <= 1'b0;
    end
    else if (any_pop)
    begin
      etx_access <= 1'b1;
    end
    else if (etx_ack)
    begin
      etx_access <= 1'b0;
    end
  end

  // Payload loads only on a pop
  always_ff @(posedge tx_lclk_div4)
  begin
    if (wr_pop)
    begin
      etx_packet <= wr_sub;
    end
    else if (rd_pop)
    begin
      etx_packet <= rd_sub;
    end
    else if (rr_pop)
    begin
      // Responses pass through untouched
      etx_packet <= rr_head;
    end
  end

  // At most one channel drained per cycle
  a_pop_onehot: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    $onehot0({wr_pop, rd_pop, rr_pop}))
    else $error("etx_arbiter more than one pop");

  // IO side sees a steady packet until it acks
  a_hold_stable: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    (etx_access && !etx_ack) |=> (etx_access && $stable(etx_packet)))
    else $error("etx_arbiter packet changed before ack");

endmodule

// ==== source/etx_fifo.sv ====
// First-word-fall-through packet FIFO, one per transmit channel
// Head is valid whenever empty is low
// Producer must not push while full, consumer must not pop while empty
// Flags follow a push or pop one cycle later
module etx_fifo (
  input  logic             tx_lclk_div4,
  input  logic             reset,
  input  logic             push,
  input  etx_pkg::packet_t push_packet,
  input  logic             pop,
  output logic             full,
  output logic             empty,
  output etx_pkg::packet_t head
);
  import etx_pkg::*;

  // Packet storage
  packet_t               mem [FIFO_DEPTH];
  // Next slot to write
  logic [FIFO_PTR_W-1:0] wr_ptr;
  // Oldest entry
  logic [FIFO_PTR_W-1:0] rd_ptr;
  // Occupancy, 0 to FIFO_DEPTH
  logic [FIFO_CNT_W-1:0] count;

  // ####################################################################
  // Storage
  // ####################################################################

  always_ff @(posedge tx_lclk_div4)
  begin
    if (push)
    begin
      mem[wr_ptr] <= push_packet;
    end
  end

  // ####################################################################
  // Pointers and occupancy
  // ####################################################################

  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Pointers wrap naturally at the power-of-two depth
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flags straight off the registered count
  assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  // Oldest entry shown without a read cycle
  assign head  = mem[rd_ptr];

  // Producer side contract
  a_no_push_full: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    push |-> !full)
    else $error("etx_fifo push while full");

  // Arbiter side contract
  a_no_pop_empty: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    pop |-> !empty)
    else $error("etx_fifo pop while empty");

endmodule

// ==== source/etx_pkg.sv ====
// Shared types and constants for the eMesh transmit path
// Packet layout is fixed by the link at 104 bits
// FIFO_DEPTH must stay a power of two since pointers wrap on overflow
// Config offsets are 4-bit Wishbone word offsets
package etx_pkg;

  // ####################################################################
  // Width types
  // ####################################################################

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  ctrlmode_t;
  // Config register offset
  typedef logic [3:0]  cfg_adr_t;

  // ####################################################################
  // eMesh packet, MSB first
  // ####################################################################

  typedef struct packed {
    addr_t      srcaddr;
    data_t      data;
    addr_t      dstaddr;
    // Lands on bits 7 to 4
    ctrlmode_t  ctrlmode;
    logic [1:0] datamode;
    logic       write;
    logic       access;
  } packet_t;

  // ####################################################################
  // Wishbone classic config bus
  // ####################################################################

  // Host to slave
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    cfg_adr_t adr;
    data_t    dat_w;
  } wb_req_t;

  // Slave to host
  typedef struct packed {
    logic  ack;
    data_t dat_r;
  } wb_rsp_t;

  // Channel FIFO sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Register map
  localparam cfg_adr_t CFG_CTRL_ADR   = 4'd0;
  localparam cfg_adr_t CFG_COUNT_ADR  = 4'd4;
  localparam int       CFG_BYPASS_BIT = 4;

endpackage
